// File: rtl/datapath_consts.svh
// datapath widths, register count and reset fetch address
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// data and address width
`define DP_WORD_W 32

// scalar register file size
`define DP_REG_N 16

// register index width, log2 of DP_REG_N
`define DP_REG_W 4

// first instruction address after reset
`define DP_RESET_PC 32'h0000_0000

// instruction field positions
//   opcode 31:28, rd 27:24, rs1 23:20, rs2 19:16, imm 15:0
// r0 is hardwired to zero in the register file

`endif

// File: rtl/datapath_pkg.sv
// opcode, functional unit select and scoreboard state enums
package datapath_pkg;

    // 4-bit opcode in instruction bits 31:28
    // codes not listed here behave as a no-op
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7,
        OP_BEQ  = 4'h8,
        OP_JAL  = 4'h9,
        OP_HALT = 4'ha,
        OP_NOP  = 4'hf
    } opcode_t;

    // unit picked by the scoreboard at issue
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_LS   = 2'd2,
        FU_BR   = 2'd3
    } fu_sel_t;

    // scoreboard FSM
    typedef enum logic [2:0] {
        SB_RUN         = 3'd0,
        SB_BRANCH_WAIT = 3'd1,
        SB_MEM_WAIT    = 3'd2,
        SB_DRAIN       = 3'd3,
        SB_HALTED      = 3'd4
    } sb_state_t;

endpackage

// File: rtl/fetch_stage.sv
// fetch stage: program counter, instruction request and fetch-to-scoreboard latch
`timescale 1ns/1ns
`include "datapath_consts.svh"

module fetch_stage (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  ihit,
    input  logic [`DP_WORD_W-1:0] imemload,
    input  logic                  freeze,
    input  logic                  redirect,
    input  logic [`DP_WORD_W-1:0] redirect_pc,
    output logic                  imemREN,
    output logic [`DP_WORD_W-1:0] imemaddr,
    output logic                  instr_valid,
    output logic [`DP_WORD_W-1:0] instr,
    output logic [`DP_WORD_W-1:0] pc
);
    logic [`DP_WORD_W-1:0] fetch_pc;
    logic                  fetch_done;

    // no request while the scoreboard holds the latch
    assign imemREN    = !freeze;
    assign imemaddr   = fetch_pc;
    assign fetch_done = imemREN && ihit;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fetch_pc    <= `DP_RESET_PC;
            instr_valid <= 1'b0;
        end else if (redirect) begin
            // wrong-path word is dropped, restart at target
            fetch_pc    <= redirect_pc;
            instr_valid <= 1'b0;
        end else begin
            if (fetch_done) begin
                fetch_pc <= fetch_pc + `DP_WORD_W'(4);
            end
            // latch either consumed or empty when not frozen
            if (!freeze) begin
                instr_valid <= fetch_done;
            end
        end
    end

    // latch payload
    always_ff @(posedge CLK) begin
        if (!redirect && fetch_done) begin
            instr <= imemload;
            pc    <= fetch_pc;
        end
    end

endmodule

// File: rtl/scoreboard.sv
// scoreboard: decode, pending-write tracking, issue control and halt sequencing
`timescale 1ns/1ns
`include "datapath_consts.svh"

module scoreboard (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  instr_valid,
    input  logic [`DP_WORD_W-1:0] instr,
    input  logic [`DP_WORD_W-1:0] pc,
    input  logic [`DP_WORD_W-1:0] rdat1,
    input  logic [`DP_WORD_W-1:0] rdat2,
    input  logic                  busy,
    input  logic                  branch_resolved,
    input  logic                  wb_en,
    input  logic [`DP_REG_W-1:0]  wb_sel,
    output logic                  freeze,
    output logic [`DP_REG_W-1:0]  rs1_sel,
    output logic [`DP_REG_W-1:0]  rs2_sel,
    output logic                  issue_valid,
    output datapath_pkg::opcode_t issue_op,
    output datapath_pkg::fu_sel_t issue_fu,
    output logic [`DP_REG_W-1:0]  issue_rd,
    output logic [`DP_WORD_W-1:0] issue_a,
    output logic [`DP_WORD_W-1:0] issue_b,
    output logic [`DP_WORD_W-1:0] issue_imm,
    output logic [`DP_WORD_W-1:0] issue_pc
);
    import datapath_pkg::*;

    sb_state_t             state;
    sb_state_t             next_state;
    opcode_t               op;
    fu_sel_t               fu;
    logic [`DP_REG_W-1:0]  rd;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  writes_rd;
    logic [`DP_REG_N-1:0]  pending;
    logic                  hazard;
    logic                  may_issue;
    logic                  issue_now;

    // field decode
    assign op      = opcode_t'(instr[31:28]);
    assign rd      = instr[27:24];
    assign rs1_sel = instr[23:20];
    assign rs2_sel = instr[19:16];

    always_comb begin
        fu        = FU_NONE;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                fu        = FU_ALU;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_ADDI: begin
                fu        = FU_ALU;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_LW: begin
                fu        = FU_LS;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_SW: begin
                fu       = FU_LS;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_BEQ: begin
                fu       = FU_BR;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_JAL: begin
                fu        = FU_BR;
                writes_rd = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // RAW on sources, WAW on destination
    assign hazard = (uses_rs1 && pending[rs1_sel]) || (uses_rs2 && pending[rs2_sel])
                    || (writes_rd && pending[rd]);
    // HALT only goes once every write has landed
    assign may_issue = instr_valid && !hazard && !busy
                       && ((op != OP_HALT) || (pending == '0));
    assign issue_now = may_issue
                       && (state inside {SB_RUN, SB_MEM_WAIT, SB_DRAIN});

    always_comb begin
        next_state = state;
        case (state)
            SB_RUN, SB_MEM_WAIT: begin
                if (issue_now) begin
                    if (fu == FU_BR) next_state = SB_BRANCH_WAIT;
                    else if (fu == FU_LS) next_state = SB_MEM_WAIT;
                    else if (op == OP_HALT) next_state = SB_HALTED;
                    else next_state = SB_RUN;
                end else if (instr_valid && (op == OP_HALT)) begin
                    next_state = SB_DRAIN;
                end else if (!busy) begin
                    next_state = SB_RUN;
                end
            end
            SB_BRANCH_WAIT: if (branch_resolved) next_state = SB_RUN;
            SB_DRAIN:       if (issue_now) next_state = SB_HALTED;
            default:        next_state = state;
        endcase
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state   <= SB_RUN;
            pending <= '0;
        end else begin
            state <= next_state;
            if (wb_en) pending[wb_sel] <= 1'b0;
            // r0 never waits on a write
            if (issue_now && writes_rd && (rd != '0)) pending[rd] <= 1'b1;
        end
    end

    // hold the fetch latch while stalled, and for good once halted
    assign freeze = (state == SB_HALTED) || (instr_valid && !issue_now);

    assign issue_valid = issue_now;
    assign issue_op    = op;
    assign issue_fu    = fu;
    assign issue_rd    = rd;
    assign issue_a     = rdat1;
    assign issue_b     = rdat2;
    assign issue_imm   = {{(`DP_WORD_W-16){instr[15]}}, instr[15:0]};
    assign issue_pc    = pc;

endmodule

// File: rtl/execute.sv
// execute stage: ALU, branch unit, scalar load/store and execute-to-writeback latch
`timescale 1ns/1ns
`include "datapath_consts.svh"

module execute (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  issue_valid,
    input  datapath_pkg::opcode_t issue_op,
    input  datapath_pkg::fu_sel_t issue_fu,
    input  logic [`DP_REG_W-1:0]  issue_rd,
    input  logic [`DP_WORD_W-1:0] issue_a,
    input  logic [`DP_WORD_W-1:0] issue_b,
    input  logic [`DP_WORD_W-1:0] issue_imm,
    input  logic [`DP_WORD_W-1:0] issue_pc,
    input  logic                  dhit,
    input  logic [`DP_WORD_W-1:0] dmemload,
    output logic                  dmemREN,
    output logic                  dmemWEN,
    output logic [`DP_WORD_W-1:0] dmemstore,
    output logic [`DP_WORD_W-1:0] dmemaddr,
    output logic                  busy,
    output logic                  redirect,
    output logic [`DP_WORD_W-1:0] redirect_pc,
    output logic                  branch_resolved,
    output logic                  res_valid,
    output logic [`DP_REG_W-1:0]  res_sel,
    output logic [`DP_WORD_W-1:0] res_wdat,
    output logic                  halt
);
    import datapath_pkg::*;

    logic                  alu_go;
    logic                  ls_go;
    logic                  br_go;
    logic                  link_go;
    logic                  br_taken;
    logic                  load_done;
    logic                  ls_active;
    logic                  ls_write;
    logic [`DP_REG_W-1:0]  ls_rd;
    logic [`DP_WORD_W-1:0] alu_out;

    assign alu_go  = issue_valid && (issue_fu == FU_ALU);
    assign ls_go   = issue_valid && (issue_fu == FU_LS);
    assign br_go   = issue_valid && (issue_fu == FU_BR);
    assign link_go = br_go && (issue_op == OP_JAL);

    always_comb begin
        case (issue_op)
            OP_SUB:  alu_out = issue_a - issue_b;
            OP_AND:  alu_out = issue_a & issue_b;
            OP_OR:   alu_out = issue_a | issue_b;
            OP_XOR:  alu_out = issue_a ^ issue_b;
            OP_ADDI: alu_out = issue_a + issue_imm;
            default: alu_out = issue_a + issue_b;
        endcase
    end

    // predicted not-taken, so only a taken branch or a jump redirects
    assign br_taken = (issue_op == OP_JAL)
                      || ((issue_op == OP_BEQ) && (issue_a == issue_b));

    // request stays up until dhit
    assign busy      = ls_active;
    assign dmemREN   = ls_active && !ls_write;
    assign dmemWEN   = ls_active && ls_write;
    assign load_done = ls_active && dhit && !ls_write;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ls_active       <= 1'b0;
            res_valid       <= 1'b0;
            redirect        <= 1'b0;
            branch_resolved <= 1'b0;
            halt            <= 1'b0;
        end else begin
            if (ls_go) ls_active <= 1'b1;
            else if (dhit) ls_active <= 1'b0;
            res_valid       <= load_done || alu_go || link_go;
            redirect        <= br_go && br_taken;
            branch_resolved <= br_go;
            // sticky once HALT issues
            halt <= halt || (issue_valid && (issue_op == OP_HALT));
        end
    end

    always_ff @(posedge CLK) begin
        if (ls_go) begin
            ls_write  <= (issue_op == OP_SW);
            ls_rd     <= issue_rd;
            dmemaddr  <= issue_a + issue_imm;
            dmemstore <= issue_b;
        end
        if (br_go) begin
            redirect_pc <= issue_pc + {issue_imm[`DP_WORD_W-3:0], 2'b00};
        end
        // busy blocks issue, so a load result never meets another one
        if (load_done) begin
            res_sel  <= ls_rd;
            res_wdat <= dmemload;
        end else if (alu_go) begin
            res_sel  <= issue_rd;
            res_wdat <= alu_out;
        end else if (link_go) begin
            res_sel  <= issue_rd;
            res_wdat <= issue_pc + `DP_WORD_W'(4);
        end
    end

endmodule

// File: rtl/writeback.sv
// writeback stage: register file with one write port and two read ports
`timescale 1ns/1ns
`include "datapath_consts.svh"

module writeback (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  res_valid,
    input  logic [`DP_REG_W-1:0]  res_sel,
    input  logic [`DP_WORD_W-1:0] res_wdat,
    input  logic [`DP_REG_W-1:0]  rs1_sel,
    input  logic [`DP_REG_W-1:0]  rs2_sel,
    output logic [`DP_WORD_W-1:0] rdat1,
    output logic [`DP_WORD_W-1:0] rdat2,
    output logic                  wb_en,
    output logic [`DP_REG_W-1:0]  wb_sel
);
    logic [`DP_WORD_W-1:0] regs [`DP_REG_N];

    // r0 writes are dropped
    assign wb_en  = res_valid && (res_sel != '0);
    assign wb_sel = res_sel;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `DP_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_sel] <= res_wdat;
        end
    end

    // no bypass, new value visible the cycle after the write
    assign rdat1 = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rdat2 = (rs2_sel == '0) ? '0 : regs[rs2_sel];

endmodule

// File: rtl/sc_datapath.sv
// top level: fetch, scoreboard, execute and writeback wired to the memory ports
`timescale 1ns/1ns
`include "datapath_consts.svh"

module sc_datapath (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  ihit,
    input  logic [`DP_WORD_W-1:0] imemload,
    input  logic                  dhit,
    input  logic [`DP_WORD_W-1:0] dmemload,
    output logic                  imemREN,
    output logic [`DP_WORD_W-1:0] imemaddr,
    output logic                  dmemREN,
    output logic                  dmemWEN,
    output logic [`DP_WORD_W-1:0] dmemstore,
    output logic [`DP_WORD_W-1:0] dmemaddr,
    output logic                  halt
);
    // fetch to scoreboard
    logic                  instr_valid;
    logic [`DP_WORD_W-1:0] instr;
    logic [`DP_WORD_W-1:0] pc;
    logic                  freeze;

    // scoreboard to execute
    logic                  issue_valid;
    datapath_pkg::opcode_t issue_op;
    datapath_pkg::fu_sel_t issue_fu;
    logic [`DP_REG_W-1:0]  issue_rd;
    logic [`DP_WORD_W-1:0] issue_a;
    logic [`DP_WORD_W-1:0] issue_b;
    logic [`DP_WORD_W-1:0] issue_imm;
    logic [`DP_WORD_W-1:0] issue_pc;

    // execute feedback and result latch
    logic                  busy;
    logic                  redirect;
    logic [`DP_WORD_W-1:0] redirect_pc;
    logic                  branch_resolved;
    logic                  res_valid;
    logic [`DP_REG_W-1:0]  res_sel;
    logic [`DP_WORD_W-1:0] res_wdat;

    // register file ports
    logic [`DP_REG_W-1:0]  rs1_sel;
    logic [`DP_REG_W-1:0]  rs2_sel;
    logic [`DP_WORD_W-1:0] rdat1;
    logic [`DP_WORD_W-1:0] rdat2;
    logic                  wb_en;
    logic [`DP_REG_W-1:0]  wb_sel;

    fetch_stage fetch_inst (.*);

    scoreboard scoreboard_inst (.*);

    execute execute_inst (.*);

    writeback writeback_inst (.*);

endmodule

// File: bench/sc_datapath_assertions.sv
// bound checks on the data request handshake, fetch after halt and halt stickiness
`timescale 1ns/1ns
`include "datapath_consts.svh"

module sc_datapath_assertions (
    input logic                  CLK,
    input logic                  nrst,
    input logic                  imemREN,
    input logic                  dmemREN,
    input logic                  dmemWEN,
    input logic [`DP_WORD_W-1:0] dmemaddr,
    input logic [`DP_WORD_W-1:0] dmemstore,
    input logic                  dhit,
    input logic                  halt
);
    int fail_count = 0;

    // one data access kind at a time
    assert property (@(posedge CLK) disable iff (!nrst) !(dmemREN && dmemWEN))
        else begin
            $error("dmemREN and dmemWEN high together");
            fail_count++;
        end

    // load request holds until dhit
    assert property (@(posedge CLK) disable iff (!nrst)
        (dmemREN && !dhit) |=> (dmemREN && $stable(dmemaddr)))
        else begin
            $error("load request changed before dhit");
            fail_count++;
        end

    // store request and data hold until dhit
    assert property (@(posedge CLK) disable iff (!nrst)
        (dmemWEN && !dhit) |=> (dmemWEN && $stable(dmemaddr) && $stable(dmemstore)))
        else begin
            $error("store request changed before dhit");
            fail_count++;
        end

    // once halted, quiet memory ports and halt stays up
    assert property (@(posedge CLK) disable iff (!nrst)
        halt |=> (halt && !imemREN && !dmemREN && !dmemWEN))
        else begin
            $error("activity or halt drop after halt");
            fail_count++;
        end

endmodule

bind sc_datapath sc_datapath_assertions assertions_inst (.*);

// File: bench/sc_datapath_tb.sv
// clock, reset, memory models, stimulus table, program builder and checks for sc_datapath
`timescale 1ns/1ns
`include "datapath_consts.svh"

module sc_datapath_tb;
    import datapath_pkg::*;

    localparam int ROM_WORDS = 256;
    localparam int RAM_WORDS = 64;
    localparam int ROWS      = 12;
    localparam int LOAD_ADDR = 'h80;
    localparam int SUM_ADDR  = 'h84;
    localparam int ZERO_ADDR = 'h88;
    localparam logic [15:0] MARKER = 16'h0bad;

    logic                  CLK;
    logic                  nrst;
    logic                  ihit;
    logic [`DP_WORD_W-1:0] imemload;
    logic                  dhit;
    logic [`DP_WORD_W-1:0] dmemload;
    logic                  imemREN;
    logic [`DP_WORD_W-1:0] imemaddr;
    logic                  dmemREN;
    logic                  dmemWEN;
    logic [`DP_WORD_W-1:0] dmemstore;
    logic [`DP_WORD_W-1:0] dmemaddr;
    logic                  halt;

    // op, operand a, operand b, expected branch outcome
    opcode_t     row_op    [ROWS] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI,
                                      OP_ADDI, OP_BEQ, OP_BEQ, OP_JAL, OP_ADD, OP_BEQ};
    logic [15:0] row_a     [ROWS] = '{16'h1234, 16'h0010, 16'hf0f0, 16'h0f00, 16'h5555,
                                      16'h7fff, 16'h0100, 16'h0033, 16'h0033, 16'h0000,
                                      16'h8000, 16'hffff};
    logic [15:0] row_b     [ROWS] = '{16'h0042, 16'h0025, 16'h3c3c, 16'h8001, 16'hffff,
                                      16'h0001, 16'hff00, 16'h0033, 16'h0034, 16'h0000,
                                      16'h8000, 16'hffff};
    logic        row_taken [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                                      1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};

    logic [`DP_WORD_W-1:0] rom      [ROM_WORDS];
    logic [`DP_WORD_W-1:0] ram      [RAM_WORDS];
    logic [`DP_WORD_W-1:0] exp_mem  [RAM_WORDS];
    logic [`DP_WORD_W-1:0] exp_addr [$];
    logic [`DP_WORD_W-1:0] exp_data [$];
    logic [31:0]           lfsr = 32'hc267;
    logic                  i_pending;
    logic                  d_pending;
    logic [`DP_WORD_W-1:0] i_addr;
    int                    i_wait;
    int                    d_wait;
    int                    n_instr;
    int                    n_seen;
    int                    cycles;
    int                    limit;

    sc_datapath sc_datapath_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    // Galois LFSR stepped once per random bit
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function int draw_wait();
        int w;
        w = 0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_step(lfsr);
            w = (w << 1) | int'(lfsr[0]);
        end
        return w;
    endfunction

    function automatic logic [31:0] encode_instr(opcode_t op, int rd, int rs1, int rs2,
                                                 logic [15:0] imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), imm};
    endfunction

    function automatic logic [31:0] sext(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // register result by the ISA rules
    function automatic logic [31:0] model_op(opcode_t op, logic [31:0] x, logic [31:0] y);
        case (op)
            OP_ADD, OP_ADDI: return x + y;
            OP_SUB:          return x - y;
            OP_AND:          return x & y;
            OP_OR:           return x | y;
            OP_XOR:          return x ^ y;
            default:         return 32'h0;
        endcase
    endfunction

    // unused ROM words are no-ops tagged with their index
    function automatic logic [31:0] rom_fill(int i);
        return {OP_NOP, 28'(i)};
    endfunction

    function automatic logic [31:0] ram_fill(int i);
        return 32'hc0de_0000 ^ (i * 32'h0001_0001);
    endfunction

    task emit(logic [31:0] word);
        rom[n_instr] = word;
        n_instr++;
    endtask

    task expect_store(int addr, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_mem[addr / 4] = data;
    endtask

    task build_program();
        logic        taken;
        logic [31:0] link;
        n_instr = 0;
        for (int r = 0; r < ROWS; r++) begin
            emit(encode_instr(OP_ADDI, 1, 0, 0, row_a[r]));
            emit(encode_instr(OP_ADDI, 2, 0, 0, row_b[r]));
            case (row_op[r])
                OP_BEQ: begin
                    taken = (sext(row_a[r]) == sext(row_b[r]));
                    check_value("table branch flag", 32'(taken), 32'(row_taken[r]));
                    emit(encode_instr(OP_ADDI, 4, 0, 0, MARKER));
                    emit(encode_instr(OP_BEQ, 0, 1, 2, 16'd2));
                    // marker store in the branch shadow
                    emit(encode_instr(OP_SW, 0, 0, 4, 16'(4 * r)));
                    if (!taken) expect_store(4 * r, sext(MARKER));
                end
                OP_JAL: begin
                    link = 32'(4 * n_instr + 4);
                    emit(encode_instr(OP_JAL, 3, 0, 0, 16'd2));
                    // skipped by the jump
                    emit(encode_instr(OP_SW, 0, 0, 1, 16'(4 * r)));
                    emit(encode_instr(OP_SW, 0, 0, 3, 16'(4 * r)));
                    expect_store(4 * r, link);
                end
                OP_ADDI: begin
                    emit(encode_instr(OP_ADDI, 3, 1, 0, row_b[r]));
                    emit(encode_instr(OP_SW, 0, 0, 3, 16'(4 * r)));
                    expect_store(4 * r, model_op(OP_ADDI, sext(row_a[r]), sext(row_b[r])));
                end
                default: begin
                    emit(encode_instr(row_op[r], 3, 1, 2, 16'h0));
                    emit(encode_instr(OP_SW, 0, 0, 3, 16'(4 * r)));
                    expect_store(4 * r, model_op(row_op[r], sext(row_a[r]), sext(row_b[r])));
                end
            endcase
        end
        // reload rows 0, 1 and 4, store one back and the sum
        emit(encode_instr(OP_LW, 5, 0, 0, 16'd0));
        emit(encode_instr(OP_LW, 6, 0, 0, 16'd4));
        emit(encode_instr(OP_LW, 7, 0, 0, 16'd16));
        emit(encode_instr(OP_SW, 0, 0, 7, 16'(LOAD_ADDR)));
        expect_store(LOAD_ADDR, exp_mem[4]);
        emit(encode_instr(OP_ADD, 8, 5, 6, 16'h0));
        emit(encode_instr(OP_ADD, 8, 8, 7, 16'h0));
        emit(encode_instr(OP_SW, 0, 0, 8, 16'(SUM_ADDR)));
        expect_store(SUM_ADDR, exp_mem[0] + exp_mem[1] + exp_mem[4]);
        // r0 keeps zero after a write
        emit(encode_instr(OP_ADDI, 0, 0, 0, 16'h1234));
        emit(encode_instr(OP_SW, 0, 0, 0, 16'(ZERO_ADDR)));
        expect_store(ZERO_ADDR, 32'h0);
        emit(encode_instr(OP_HALT, 0, 0, 0, 16'h0));
    endtask

    task serve_imem();
        if (!imemREN) begin
            ihit      = 1'b0;
            i_pending = 1'b0;
        end else begin
            // new address starts a fresh wait
            if (!i_pending || (imemaddr != i_addr)) begin
                i_pending = 1'b1;
                i_addr    = imemaddr;
                i_wait    = draw_wait();
            end
            if (i_wait > 0) begin
                ihit   = 1'b0;
                i_wait = i_wait - 1;
            end else begin
                ihit      = 1'b1;
                imemload  = rom[imemaddr[9:2]];
                i_pending = 1'b0;
            end
        end
    endtask

    task record_store();
        if (n_seen >= exp_addr.size()) begin
            abort_run($sformatf("unexpected store of 0x%08h to 0x%08h", dmemstore, dmemaddr));
        end
        check_value("dmemaddr", dmemaddr, exp_addr[n_seen]);
        check_value("dmemstore", dmemstore, exp_data[n_seen]);
        n_seen++;
    endtask

    task serve_dmem();
        if (!(dmemREN || dmemWEN)) begin
            dhit      = 1'b0;
            d_pending = 1'b0;
        end else begin
            if (!d_pending) begin
                d_pending = 1'b1;
                d_wait    = draw_wait();
            end
            if (d_wait > 0) begin
                dhit   = 1'b0;
                d_wait = d_wait - 1;
            end else begin
                dhit      = 1'b1;
                d_pending = 1'b0;
                if (dmemWEN) begin
                    record_store();
                    ram[dmemaddr[7:2]] = dmemstore;
                end else begin
                    dmemload = ram[dmemaddr[7:2]];
                end
            end
        end
    endtask

    initial begin : memory_model
        ihit      = 1'b0;
        imemload  = '0;
        dhit      = 1'b0;
        dmemload  = '0;
        i_pending = 1'b0;
        d_pending = 1'b0;
        i_addr    = '0;
        i_wait    = 0;
        d_wait    = 0;
        n_seen    = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = ram_fill(i);
        end
        forever begin
            @(posedge CLK);
            #1;
            serve_imem();
            serve_dmem();
            check_value("assertion failures",
                        sc_datapath_inst.assertions_inst.fail_count, 0);
            // no traffic once halted
            if (halt) begin
                check_value("imemREN", 32'(imemREN), 32'h0);
                check_value("dmemREN", 32'(dmemREN), 32'h0);
                check_value("dmemWEN", 32'(dmemWEN), 32'h0);
            end
        end
    end

    initial begin : main
        nrst = 1'b0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = rom_fill(i);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            exp_mem[i] = ram_fill(i);
        end
        build_program();
        limit = n_instr * 12;
        repeat (4) @(posedge CLK);
        #1;
        nrst   = 1'b1;
        cycles = 0;
        // halt sampled mid-cycle
        while (!halt && (cycles < limit)) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halt) begin
            abort_run($sformatf("processor never halted within %0d cycles", limit));
        end else begin
            check_value("stores before halt", n_seen, exp_addr.size());
            repeat (20) @(negedge CLK);
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/datapath_pkg.sv
rtl/fetch_stage.sv
rtl/scoreboard.sv
rtl/execute.sv
rtl/writeback.sv
rtl/sc_datapath.sv
bench/sc_datapath_assertions.sv
bench/sc_datapath_tb.sv
